// ==== id_defines.svh ====
// Width and reset-value macros for the RV32I decode stage
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

///////////////////////////////////////////////////////////////////////
// Data path widths
///////////////////////////////////////////////////////////////////////
`define XLEN       32
`define INSTR_W    32
`define REG_ADDR_W 5   // x0..x31

// One flag per exception cause
`define NUM_CAUSES 12

///////////////////////////////////////////////////////////////////////
// Reset values
///////////////////////////////////////////////////////////////////////
`define PC_INIT 32'h0000_0200   // Boot address

`endif

// ==== rv_isa_pkg.sv ====
// RV32I encoding constants: opcodes, field positions, system words and causes
`include "id_defines.svh"

package rv_isa_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Major opcodes, instruction bits 6..2
  ///////////////////////////////////////////////////////////////////////
  localparam int OPC_POS = 2;
  localparam int OPC_W   = 5;

  typedef enum logic [OPC_W-1:0] {
    LOAD     = 5'b00000,
    MISC_MEM = 5'b00011,
    OP_IMM   = 5'b00100,
    AUIPC    = 5'b00101,
    STORE    = 5'b01000,
    OP       = 5'b01100,
    LUI      = 5'b01101,
    BRANCH   = 5'b11000,
    JALR     = 5'b11001,
    JAL      = 5'b11011,
    SYSTEM   = 5'b11100
  } opcode_e;

  // Lowest bit of each field
  localparam int RD_POS     = 7;
  localparam int FUNCT3_POS = 12;
  localparam int RS1_POS    = 15;
  localparam int RS2_POS    = 20;
  localparam int FUNCT7_POS = 25;

  // Fixed instruction words
  localparam logic [`INSTR_W-1:0] INSTR_NOP     = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [`INSTR_W-1:0] INSTR_ECALL   = 32'h0000_0073;
  localparam logic [`INSTR_W-1:0] INSTR_EBREAK  = 32'h0010_0073;
  localparam logic [`INSTR_W-1:0] INSTR_MRET    = 32'h3020_0073;
  localparam logic [`INSTR_W-1:0] INSTR_FENCE_I = 32'h0000_100f;

  // Bit positions in the cause vector
  localparam int CAUSE_FETCH_FAULT = 1;
  localparam int CAUSE_ILLEGAL     = 2;
  localparam int CAUSE_BREAKPOINT  = 3;
  localparam int CAUSE_MCALL       = 11;

  function automatic opcode_e opcode_of(input logic [`INSTR_W-1:0] instr);
    return opcode_e'(instr[OPC_POS +: OPC_W]);
  endfunction

  // Instructions whose result lands in rd
  function automatic logic writes_rd(input opcode_e opc);
    case (opc)
      LOAD, OP_IMM, AUIPC, OP, LUI, JAL, JALR, SYSTEM: return 1'b1;
      default:                                         return 1'b0;
    endcase
  endfunction

endpackage

// ==== id_types_pkg.sv ====
// Data and flag types shared by the decode stage units
`include "id_defines.svh"

package id_types_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Words
  ///////////////////////////////////////////////////////////////////////
  typedef logic [`XLEN-1:0]    xlen_t;
  typedef logic [`INSTR_W-1:0] instr_t;

  // Register index x0..x31
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Indexed by the CAUSE_* positions of the ISA package
  typedef logic [`NUM_CAUSES-1:0] cause_vec_t;

  ///////////////////////////////////////////////////////////////////////
  // Per-operand flags
  ///////////////////////////////////////////////////////////////////////
  // Use-RF flags and each bypass pair
  typedef struct packed {
    logic opa;
    logic opb;
  } opnd_flags_t;

endpackage

// ==== id_stage_if.sv ====
// Decode stage bus carrying the fetch word and the stage-advance control
`timescale 1ns/1ns

interface id_stage_if;

  // Word offered by fetch
  id_types_pkg::instr_t    fetch_instr;
  id_types_pkg::xlen_t     fetch_pc;
  logic                    fetch_valid;

  logic                    advance;    // ID registers load this edge

  // Instruction currently held in ID
  id_types_pkg::reg_addr_t id_rd;
  logic                    id_rd_we;   // Valid and writes rd

  modport ctrl (
    output fetch_instr,
    output fetch_pc,
    output fetch_valid,
    output advance,
    output id_rd,
    output id_rd_we
  );

  modport unit (
    input fetch_instr,
    input fetch_pc,
    input fetch_valid,
    input advance,
    input id_rd,
    input id_rd_we
  );

endinterface

// ==== id_pipe_ctrl.sv ====
// ID stage registers, fetch/EX handshake, flush and ID destination tracking
`timescale 1ns/1ns
`include "id_defines.svh"

module id_pipe_ctrl (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    if_valid,
  output logic                    if_ready,
  input  id_types_pkg::instr_t    if_instr,
  input  id_types_pkg::xlen_t     if_pc,
  input  logic                    ex_ready,
  input  logic                    flush,
  input  id_types_pkg::xlen_t     flush_pc,
  output logic                    id_valid,
  output id_types_pkg::instr_t    id_instr,
  output id_types_pkg::xlen_t     id_pc,
  output id_types_pkg::reg_addr_t id_src1,
  output id_types_pkg::reg_addr_t id_src2,
  id_stage_if.ctrl                stg
);

  logic advance;
  logic accept;

  // Stage is free when empty or when EX takes the current word
  assign if_ready = ex_ready | ~id_valid;
  assign advance  = if_ready;
  assign accept   = advance & if_valid;

  assign stg.fetch_instr = if_instr;
  assign stg.fetch_pc    = if_pc;
  assign stg.fetch_valid = if_valid;
  assign stg.advance     = advance;

  ///////////////////////////////////////////////////////////////////////
  // ID registers
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_valid <= 1'b0;
      id_pc    <= `PC_INIT;
      id_instr <= rv_isa_pkg::INSTR_NOP;
    end else if (flush) begin
      id_valid <= 1'b0;       // Accepted word is dropped
      id_pc    <= flush_pc;
    end else if (advance) begin
      id_valid <= if_valid;
      if (accept) begin
        id_pc    <= if_pc;
        id_instr <= if_instr;
      end
    end
  end

  // RF addresses look one word ahead while the stage moves
  assign id_src1 = advance ? if_instr[rv_isa_pkg::RS1_POS +: `REG_ADDR_W]
                           : id_instr[rv_isa_pkg::RS1_POS +: `REG_ADDR_W];
  assign id_src2 = advance ? if_instr[rv_isa_pkg::RS2_POS +: `REG_ADDR_W]
                           : id_instr[rv_isa_pkg::RS2_POS +: `REG_ADDR_W];

  // Destination of the word that moves on to EX
  assign stg.id_rd    = id_instr[rv_isa_pkg::RD_POS +: `REG_ADDR_W];
  assign stg.id_rd_we = id_valid & rv_isa_pkg::writes_rd(rv_isa_pkg::opcode_of(id_instr));

  ///////////////////////////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////////////////////////
  a_flush_kills: assert property (@(posedge clk) disable iff (!rstn)
    flush |=> !id_valid);

  a_backpressure_hold: assert property (@(posedge clk) disable iff (!rstn)
    (id_valid && !ex_ready && !flush) |=> id_valid && $stable(id_instr) && $stable(id_pc));

endmodule

// ==== instr_legality_check.sv ====
// RV32I legality decode of the fetch word and the registered ID cause vector
`timescale 1ns/1ns

module instr_legality_check (
  input  logic                     clk,
  input  logic                     rstn,
  id_stage_if.unit                 stg,
  input  logic                     flush,
  input  logic                     if_fault,
  output id_types_pkg::cause_vec_t id_cause
);

  rv_isa_pkg::opcode_e  opc;
  logic [2:0]           f3;
  logic [6:0]           f7;
  id_types_pkg::instr_t instr;
  logic                 illegal;
  logic                 is_csr;

  assign instr  = stg.fetch_instr;
  assign opc    = rv_isa_pkg::opcode_of(instr);
  assign f3     = instr[rv_isa_pkg::FUNCT3_POS +: 3];
  assign f7     = instr[rv_isa_pkg::FUNCT7_POS +: 7];
  assign is_csr = (f3 != 3'b000) && (f3 != 3'b100);   // CSRRW..CSRRCI

  ///////////////////////////////////////////////////////////////////////
  // Encoding table
  ///////////////////////////////////////////////////////////////////////
  always_comb begin
    illegal = 1'b1;
    case (opc)
      rv_isa_pkg::LUI,
      rv_isa_pkg::AUIPC,
      rv_isa_pkg::JAL:      illegal = 1'b0;
      rv_isa_pkg::JALR:     illegal = (f3 != 3'b000);
      rv_isa_pkg::BRANCH:   illegal = (f3[2:1] == 2'b01);          // No funct3 2 or 3
      rv_isa_pkg::LOAD:     illegal = (f3 == 3'b011) || (f3[2:1] == 2'b11);
      rv_isa_pkg::STORE:    illegal = (f3 > 3'b010);
      rv_isa_pkg::OP_IMM: begin
        // Bit 25 is shamt[5], which RV32 does not have
        case (f3)
          3'b001:  illegal = (f7 != 7'h00);
          3'b101:  illegal = (f7 != 7'h00) && (f7 != 7'h20);
          default: illegal = 1'b0;
        endcase
      end
      rv_isa_pkg::OP:
        illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
      rv_isa_pkg::MISC_MEM: illegal = !((f3 == 3'b000) || (instr == rv_isa_pkg::INSTR_FENCE_I));
      rv_isa_pkg::SYSTEM: begin
        if (is_csr) begin
          illegal = 1'b0;                                          // Any CSR address
        end else begin
          illegal = !((instr == rv_isa_pkg::INSTR_ECALL)  ||
                      (instr == rv_isa_pkg::INSTR_EBREAK) ||
                      (instr == rv_isa_pkg::INSTR_MRET));
        end
      end
      default:              illegal = 1'b1;
    endcase
  end

  ///////////////////////////////////////////////////////////////////////
  // Cause register
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_cause <= '0;
    end else if (flush) begin
      id_cause <= '0;
    end else if (stg.advance) begin
      id_cause                                <= '0;
      id_cause[rv_isa_pkg::CAUSE_FETCH_FAULT] <= stg.fetch_valid & if_fault;
      id_cause[rv_isa_pkg::CAUSE_ILLEGAL]     <= stg.fetch_valid & illegal;
      id_cause[rv_isa_pkg::CAUSE_BREAKPOINT]  <= stg.fetch_valid &
                                                 (instr == rv_isa_pkg::INSTR_EBREAK);
      id_cause[rv_isa_pkg::CAUSE_MCALL]       <= stg.fetch_valid &
                                                 (instr == rv_isa_pkg::INSTR_ECALL);
    end
  end

  // Decode outcomes exclude each other
  a_one_decode_cause: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({id_cause[rv_isa_pkg::CAUSE_ILLEGAL],
              id_cause[rv_isa_pkg::CAUSE_BREAKPOINT],
              id_cause[rv_isa_pkg::CAUSE_MCALL]}));

endmodule

// ==== operand_builder.sv ====
// Immediate extraction, operand A/B selection and use-register-file flags
`timescale 1ns/1ns
`include "id_defines.svh"

module operand_builder (
  input  logic                      clk,
  id_stage_if.unit                  stg,
  input  id_types_pkg::instr_t      wb_instr,
  input  logic                      wb_valid,
  input  id_types_pkg::xlen_t       wb_r,
  output id_types_pkg::xlen_t       id_opa,
  output id_types_pkg::xlen_t       id_opb,
  output id_types_pkg::opnd_flags_t id_use_rf
);

  id_types_pkg::xlen_t     imm_i;
  id_types_pkg::xlen_t     imm_u;
  id_types_pkg::reg_addr_t src1;
  id_types_pkg::reg_addr_t src2;
  id_types_pkg::reg_addr_t wb_rd;
  logic                    wb_we;
  logic                    wb_hit1;
  logic                    wb_hit2;

  assign src1  = stg.fetch_instr[rv_isa_pkg::RS1_POS +: `REG_ADDR_W];
  assign src2  = stg.fetch_instr[rv_isa_pkg::RS2_POS +: `REG_ADDR_W];
  assign imm_i = {{(`XLEN-12){stg.fetch_instr[31]}}, stg.fetch_instr[31:20]};
  assign imm_u = {stg.fetch_instr[31:12], 12'b0};

  // Result on wb_r is not yet in the register file
  assign wb_rd   = wb_instr[rv_isa_pkg::RD_POS +: `REG_ADDR_W];
  assign wb_we   = wb_valid & rv_isa_pkg::writes_rd(rv_isa_pkg::opcode_of(wb_instr));
  assign wb_hit1 = (src1 != '0) && (src1 == wb_rd) && wb_we;
  assign wb_hit2 = (src2 != '0) && (src2 == wb_rd) && wb_we;

  always_ff @(posedge clk) begin
    if (stg.advance) begin
      case (rv_isa_pkg::opcode_of(stg.fetch_instr))
        rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD, rv_isa_pkg::JALR: begin
          id_opa        <= wb_r;
          id_opb        <= imm_i;
          id_use_rf.opa <= ~wb_hit1;
          id_use_rf.opb <= 1'b0;
        end
        rv_isa_pkg::AUIPC: begin
          id_opa        <= stg.fetch_pc;
          id_opb        <= imm_u;
          id_use_rf     <= '0;
        end
        rv_isa_pkg::LUI: begin
          id_opa        <= '0;
          id_opb        <= imm_u;
          id_use_rf     <= '0;
        end
        rv_isa_pkg::OP, rv_isa_pkg::STORE, rv_isa_pkg::BRANCH: begin
          id_opa        <= wb_r;
          id_opb        <= wb_r;
          id_use_rf.opa <= ~wb_hit1;
          id_use_rf.opb <= ~wb_hit2;
        end
        rv_isa_pkg::SYSTEM: begin
          id_opa        <= wb_r;                                   // CSR source register
          id_opb        <= {{(`XLEN-`REG_ADDR_W){1'b0}}, src1};    // CSR immediate forms
          id_use_rf.opa <= ~wb_hit1;
          id_use_rf.opb <= 1'b0;
        end
        default: begin
          id_opa        <= '0;
          id_opb        <= '0;
          id_use_rf     <= '1;
        end
      endcase
    end
  end

endmodule

// ==== bypass_ctrl.sv ====
// Registered EX and WB bypass flags for operands A and B
`timescale 1ns/1ns
`include "id_defines.svh"

module bypass_ctrl (
  input  logic                      clk,
  input  logic                      rstn,
  id_stage_if.unit                  stg,
  input  id_types_pkg::instr_t      ex_instr,
  input  logic                      ex_valid,
  output id_types_pkg::opnd_flags_t id_byp_ex,
  output id_types_pkg::opnd_flags_t id_byp_wb
);

  rv_isa_pkg::opcode_e     opc;
  id_types_pkg::reg_addr_t src1;
  id_types_pkg::reg_addr_t src2;
  id_types_pkg::reg_addr_t ex_rd;
  logic                    ex_we;
  logic                    reads1;
  logic                    reads2;

  // Source matches a pending write; x0 never forwards
  function automatic logic dep(input id_types_pkg::reg_addr_t src,
                               input id_types_pkg::reg_addr_t dst,
                               input logic                    we);
    return (src != '0) && (src == dst) && we;
  endfunction

  assign opc  = rv_isa_pkg::opcode_of(stg.fetch_instr);
  assign src1 = stg.fetch_instr[rv_isa_pkg::RS1_POS +: `REG_ADDR_W];
  assign src2 = stg.fetch_instr[rv_isa_pkg::RS2_POS +: `REG_ADDR_W];

  assign ex_rd = ex_instr[rv_isa_pkg::RD_POS +: `REG_ADDR_W];
  assign ex_we = ex_valid & rv_isa_pkg::writes_rd(rv_isa_pkg::opcode_of(ex_instr));

  // Register-reading operands, as in the operand table
  assign reads1 = opc inside {rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD, rv_isa_pkg::JALR,
                              rv_isa_pkg::OP, rv_isa_pkg::STORE, rv_isa_pkg::BRANCH,
                              rv_isa_pkg::SYSTEM};
  assign reads2 = opc inside {rv_isa_pkg::OP, rv_isa_pkg::STORE, rv_isa_pkg::BRANCH};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_byp_ex <= '0;
      id_byp_wb <= '0;
    end else if (stg.advance) begin
      id_byp_ex.opa <= reads1 & dep(src1, stg.id_rd, stg.id_rd_we);  // ID word goes to EX
      id_byp_ex.opb <= reads2 & dep(src2, stg.id_rd, stg.id_rd_we);
      id_byp_wb.opa <= reads1 & dep(src1, ex_rd, ex_we);              // EX word goes to WB
      id_byp_wb.opb <= reads2 & dep(src2, ex_rd, ex_we);
    end
  end

  a_no_x0_bypass_a: assert property (@(posedge clk) disable iff (!rstn)
    (stg.advance && src1 == '0) |=> !id_byp_ex.opa && !id_byp_wb.opa);

  a_no_x0_bypass_b: assert property (@(posedge clk) disable iff (!rstn)
    (stg.advance && src2 == '0) |=> !id_byp_ex.opb && !id_byp_wb.opb);

endmodule

// ==== id_decode_top.sv ====
// RV32I decode stage top level joining pipe control and the decode units
`timescale 1ns/1ns

module id_decode_top (
  input  logic                      clk,
  input  logic                      rstn,
  // Fetch side
  input  logic                      if_valid,
  output logic                      if_ready,
  input  id_types_pkg::instr_t      if_instr,
  input  id_types_pkg::xlen_t       if_pc,
  input  logic                      if_fault,
  // EX side
  output logic                      id_valid,
  input  logic                      ex_ready,
  output id_types_pkg::xlen_t       id_pc,
  output id_types_pkg::instr_t      id_instr,
  output id_types_pkg::cause_vec_t  id_cause,
  output id_types_pkg::xlen_t       id_opa,
  output id_types_pkg::xlen_t       id_opb,
  output id_types_pkg::opnd_flags_t id_use_rf,
  output id_types_pkg::opnd_flags_t id_byp_ex,
  output id_types_pkg::opnd_flags_t id_byp_wb,
  // Register file
  output id_types_pkg::reg_addr_t   id_src1,
  output id_types_pkg::reg_addr_t   id_src2,
  // Later stages
  input  id_types_pkg::instr_t      ex_instr,
  input  logic                      ex_valid,
  input  id_types_pkg::instr_t      wb_instr,
  input  logic                      wb_valid,
  input  id_types_pkg::xlen_t       wb_r,
  // Redirect
  input  logic                      flush,
  input  id_types_pkg::xlen_t       flush_pc
);

  id_stage_if stg_if ();

  id_pipe_ctrl pipe_i (
    .clk, .rstn, .if_valid, .if_ready, .if_instr, .if_pc, .ex_ready,
    .flush, .flush_pc, .id_valid, .id_instr, .id_pc, .id_src1, .id_src2,
    .stg (stg_if.ctrl)
  );

  instr_legality_check legal_i (
    .clk, .rstn, .stg (stg_if.unit), .flush, .if_fault, .id_cause
  );

  operand_builder opnd_i (
    .clk, .stg (stg_if.unit), .wb_instr, .wb_valid, .wb_r,
    .id_opa, .id_opb, .id_use_rf
  );

  bypass_ctrl byp_i (
    .clk, .rstn, .stg (stg_if.unit), .ex_instr, .ex_valid, .id_byp_ex, .id_byp_wb
  );

endmodule

// ==== tb_id_decode.sv ====
// Testbench for the RV32I decode stage, with a reference model checked by assertions
`timescale 1ns/1ns
`include "id_defines.svh"

module tb_id_decode;

  localparam int NUM_WORDS = 600;
  localparam int TIMEOUT   = 64;   // Cycles any single wait may take

  logic                      clk;
  logic                      rstn;
  logic                      if_valid, if_ready, if_fault;
  logic                      id_valid, ex_ready, ex_valid, wb_valid, flush;
  id_types_pkg::instr_t      if_instr, id_instr, ex_instr, wb_instr;
  id_types_pkg::xlen_t       if_pc, id_pc, id_opa, id_opb, wb_r, flush_pc;
  id_types_pkg::cause_vec_t  id_cause;
  id_types_pkg::reg_addr_t   id_src1, id_src2;
  id_types_pkg::opnd_flags_t id_use_rf, id_byp_ex, id_byp_wb;

  ///////////////////////////////////////////////////////////////////////
  // Reference model state
  ///////////////////////////////////////////////////////////////////////
  logic                      m_valid, m_chk;
  id_types_pkg::xlen_t       m_pc, m_opa, m_opb;
  id_types_pkg::instr_t      m_instr;
  id_types_pkg::cause_vec_t  m_cause;
  id_types_pkg::opnd_flags_t m_use, m_byp_ex, m_byp_wb;
  // Scratch values of the model
  logic                      adv, wb_we, id_we, ex_we, hit1, hit2, rd1, rd2, chk;
  id_types_pkg::reg_addr_t   s1, s2, exp_src1, exp_src2;
  id_types_pkg::xlen_t       opa, opb;
  id_types_pkg::cause_vec_t  cause;

  id_types_pkg::xlen_t       fetch_pc;
  logic [31:0]               lcg_state = 32'h672be9d3;
  int                        cyc = 0;

  id_decode_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // LOAD, OP_IMM, AUIPC, OP, LUI, JAL, JALR and SYSTEM write rd
  function automatic logic writes_dest(input logic [4:0] opc);
    case (opc)
      5'b00000, 5'b00100, 5'b00101, 5'b01100, 5'b01101, 5'b11011, 5'b11001, 5'b11100:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic logic exp_illegal(input id_types_pkg::instr_t w);
    case (w[6:2])
      5'b00100: return (w[13:12] == 2'b01) && w[25];   // Shift with shamt[5]
      5'b00000, 5'b00011, 5'b00101, 5'b01000, 5'b01100, 5'b01101,
      5'b11000, 5'b11001, 5'b11011, 5'b11100:
        return 1'b0;
      default:  return 1'b1;
    endcase
  endfunction

  // Mixed encodings over x0..x3 so dependencies are common
  function automatic id_types_pkg::instr_t pick_instr(input logic [31:0] r);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = {3'b000, r[9:8]};
    rs1 = {3'b000, r[11:10]};
    rs2 = {3'b000, r[13:12]};
    imm = r[31:20];
    case (r[7:4])
      4'd0:  return {imm, rs1, 3'b000, rd, 7'b0010011};
      4'd1:  return {1'b0, r[14], 4'b0000, r[15], rs2, rs1, r[14], 2'b01, rd, 7'b0010011};
      4'd2:  return {1'b0, r[15], 5'b00000, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd3:  return {imm, rs1, 3'b010, rd, 7'b0000011};
      4'd4:  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      4'd5:  return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};
      4'd6:  return {r[31:12], rd, 7'b0110111};
      4'd7:  return {r[31:12], rd, 7'b0010111};
      4'd8:  return {imm, rs1, 3'b000, rd, 7'b1100111};
      4'd9:  return {r[31:12], rd, 7'b1101111};
      4'd10: return rv_isa_pkg::INSTR_ECALL;
      4'd11: return rv_isa_pkg::INSTR_EBREAK;
      4'd12: return rv_isa_pkg::INSTR_MRET;
      4'd13: return {12'h340, rs1, r[14], 2'b01, rd, 7'b1110011};   // CSRRW or CSRRWI
      4'd14: return {r[31:7], 7'b1111111};                          // Unknown opcode
      default: return {imm, 5'd0, 3'b000, 5'd0, 7'b0001111};        // FENCE
    endcase
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // Reference model, fed with the inputs seen at each edge
  ///////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m_valid <= 1'b0;
      m_pc    <= `PC_INIT;
      m_instr <= rv_isa_pkg::INSTR_NOP;
      m_cause <= '0;
    end else begin
      adv   = ex_ready || !m_valid;
      s1    = if_instr[19:15];
      s2    = if_instr[24:20];
      wb_we = wb_valid && writes_dest(wb_instr[6:2]);
      id_we = m_valid && writes_dest(m_instr[6:2]);
      ex_we = ex_valid && writes_dest(ex_instr[6:2]);
      cause = '0;
      cause[rv_isa_pkg::CAUSE_FETCH_FAULT] = if_valid && if_fault;
      cause[rv_isa_pkg::CAUSE_ILLEGAL]     = if_valid && exp_illegal(if_instr);
      cause[rv_isa_pkg::CAUSE_BREAKPOINT]  = if_valid && (if_instr == 32'h0010_0073);
      cause[rv_isa_pkg::CAUSE_MCALL]       = if_valid && (if_instr == 32'h0000_0073);
      if (flush) begin
        m_valid <= 1'b0;
        m_pc    <= flush_pc;
        m_cause <= '0;
      end else if (adv) begin
        m_valid <= if_valid;
        m_cause <= cause;
        if (if_valid) begin
          m_pc    <= if_pc;
          m_instr <= if_instr;
        end
      end
      // Operand table
      hit1 = (s1 != '0) && (s1 == wb_instr[11:7]) && wb_we;
      hit2 = (s2 != '0) && (s2 == wb_instr[11:7]) && wb_we;
      rd1  = 1'b1;
      rd2  = 1'b0;
      chk  = 1'b1;
      opa  = wb_r;
      opb  = wb_r;
      case (if_instr[6:2])
        5'b00100, 5'b00000, 5'b11001: opb = {{20{if_instr[31]}}, if_instr[31:20]};
        5'b00101: begin
          rd1 = 1'b0;
          opa = if_pc;
          opb = {if_instr[31:12], 12'h000};
        end
        5'b01101: begin
          rd1 = 1'b0;
          opa = '0;
          opb = {if_instr[31:12], 12'h000};
        end
        5'b01100, 5'b01000, 5'b11000: rd2 = 1'b1;
        5'b11100: opb = {27'd0, s1};
        default: begin
          rd1 = 1'b0;
          chk = 1'b0;   // Values unspecified here
        end
      endcase
      if (adv) begin
        m_chk    <= chk;
        m_opa    <= opa;
        m_opb    <= opb;
        m_use    <= chk ? {rd1 && !hit1, rd2 && !hit2} : 2'b11;
        m_byp_ex <= {rd1 && (s1 != '0) && (s1 == m_instr[11:7]) && id_we,
                     rd2 && (s2 != '0) && (s2 == m_instr[11:7]) && id_we};
        m_byp_wb <= {rd1 && (s1 != '0) && (s1 == ex_instr[11:7]) && ex_we,
                     rd2 && (s2 != '0) && (s2 == ex_instr[11:7]) && ex_we};
      end
    end
  end

  assign exp_src1 = (ex_ready || !m_valid) ? if_instr[19:15] : m_instr[19:15];
  assign exp_src2 = (ex_ready || !m_valid) ? if_instr[24:20] : m_instr[24:20];

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_with_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////////////////////////
  a_reset_valid: assert property (@(posedge clk) (!rstn && cyc > 0) |-> !id_valid)
    else report_mismatch("id_valid", $sampled(id_valid), 32'h0);

  a_reset_pc: assert property (@(posedge clk) (!rstn && cyc > 0) |-> id_pc == `PC_INIT)
    else report_mismatch("id_pc", $sampled(id_pc), `PC_INIT);

  a_reset_cause: assert property (@(posedge clk) (!rstn && cyc > 0) |-> id_cause == '0)
    else report_mismatch("id_cause", $sampled(id_cause), 32'h0);

  a_if_ready: assert property (@(posedge clk) disable iff (!rstn)
    if_ready == (ex_ready || !m_valid))
    else report_mismatch("if_ready", $sampled(if_ready), $sampled(ex_ready || !m_valid));

  a_valid: assert property (@(posedge clk) disable iff (!rstn) id_valid == m_valid)
    else report_mismatch("id_valid", $sampled(id_valid), $sampled(m_valid));

  a_pc: assert property (@(posedge clk) disable iff (!rstn) id_pc == m_pc)
    else report_mismatch("id_pc", $sampled(id_pc), $sampled(m_pc));

  a_instr: assert property (@(posedge clk) disable iff (!rstn) id_instr == m_instr)
    else report_mismatch("id_instr", $sampled(id_instr), $sampled(m_instr));

  a_cause: assert property (@(posedge clk) disable iff (!rstn) id_cause == m_cause)
    else report_mismatch("id_cause", $sampled(id_cause), $sampled(m_cause));

  a_src1: assert property (@(posedge clk) disable iff (!rstn) id_src1 == exp_src1)
    else report_mismatch("id_src1", $sampled(id_src1), $sampled(exp_src1));

  a_src2: assert property (@(posedge clk) disable iff (!rstn) id_src2 == exp_src2)
    else report_mismatch("id_src2", $sampled(id_src2), $sampled(exp_src2));

  a_opa: assert property (@(posedge clk) disable iff (!rstn)
    (m_valid && m_chk) |-> id_opa == m_opa)
    else report_mismatch("id_opa", $sampled(id_opa), $sampled(m_opa));

  a_opb: assert property (@(posedge clk) disable iff (!rstn)
    (m_valid && m_chk) |-> id_opb == m_opb)
    else report_mismatch("id_opb", $sampled(id_opb), $sampled(m_opb));

  a_use_rf: assert property (@(posedge clk) disable iff (!rstn) m_valid |-> id_use_rf == m_use)
    else report_mismatch("id_use_rf", $sampled(id_use_rf), $sampled(m_use));

  a_byp_ex: assert property (@(posedge clk) disable iff (!rstn) m_valid |-> id_byp_ex == m_byp_ex)
    else report_mismatch("id_byp_ex", $sampled(id_byp_ex), $sampled(m_byp_ex));

  a_byp_wb: assert property (@(posedge clk) disable iff (!rstn) m_valid |-> id_byp_wb == m_byp_wb)
    else report_mismatch("id_byp_wb", $sampled(id_byp_wb), $sampled(m_byp_wb));

  a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
    (id_valid && !ex_ready && !flush) |=> $stable(id_opa) && $stable(id_opb) &&
    $stable(id_cause) && $stable(id_use_rf) && $stable(id_byp_ex) && $stable(id_byp_wb))
    else stop_with_failure("ID outputs changed while EX held the stage");

  ///////////////////////////////////////////////////////////////////////
  // Stimulus
  ///////////////////////////////////////////////////////////////////////
  task automatic drive_side_inputs();
    logic [31:0] r;
    r = next_rand();
    ex_ready <= (r[1:0] != 2'b00);
    ex_valid <= r[2];
    wb_valid <= r[3];
    flush    <= (r[7:4] == 4'h0);   // Occasional redirect
    flush_pc <= {16'h0000, r[31:18], 2'b00};
    ex_instr <= pick_instr(next_rand());
    wb_instr <= pick_instr(next_rand());
    wb_r     <= next_rand();
  endtask

  task automatic idle_cycle();
    if_valid <= 1'b0;
    drive_side_inputs();
    @(posedge clk);
    if (flush) fetch_pc = flush_pc;
  endtask

  // Offer one word until it is taken or a flush drops it
  task automatic send_word(input id_types_pkg::instr_t w, input logic fault);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    if_valid <= 1'b1;
    if_instr <= w;
    if_pc    <= fetch_pc;
    if_fault <= fault;
    drive_side_inputs();
    while (!done) begin
      @(posedge clk);
      done = if_ready || flush;
      if (flush) fetch_pc = flush_pc;
      else if (if_ready) fetch_pc = fetch_pc + 32'd4;
      if (!done) begin
        waited++;
        if (waited > TIMEOUT) stop_with_failure("Fetch word was not accepted in time");
        drive_side_inputs();
      end
    end
  endtask

  initial begin
    int          i;
    int          waited;
    logic [31:0] r;
    rstn     = 1'b0;
    if_valid = 1'b0;
    if_instr = rv_isa_pkg::INSTR_NOP;
    if_pc    = '0;
    if_fault = 1'b0;
    ex_ready = 1'b0;
    ex_valid = 1'b0;
    ex_instr = rv_isa_pkg::INSTR_NOP;
    wb_valid = 1'b0;
    wb_instr = rv_isa_pkg::INSTR_NOP;
    wb_r     = '0;
    flush    = 1'b0;
    flush_pc = '0;
    fetch_pc = `PC_INIT;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    for (i = 0; i < NUM_WORDS; i++) begin
      r = next_rand();
      if (r[3:0] == 4'h0) idle_cycle();
      send_word(pick_instr(r), r[31:28] == 4'hf);
    end
    // Drain the stage
    if_valid <= 1'b0;
    ex_ready <= 1'b1;
    flush    <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) stop_with_failure("ID stage did not drain");
    end while (id_valid);
    @(posedge clk);
    @(negedge clk);   // Let the last edge's checks complete
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
rv_isa_pkg.sv
id_types_pkg.sv
id_stage_if.sv
id_pipe_ctrl.sv
instr_legality_check.sv
operand_builder.sv
bypass_ctrl.sv
id_decode_top.sv
tb_id_decode.sv

// ==== Bender.yml ====
package:
  name: id_decode

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - id_types_pkg.sv
      - id_stage_if.sv
      - id_pipe_ctrl.sv
      - instr_legality_check.sv
      - operand_builder.sv
      - bypass_ctrl.sv
      - id_decode_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_id_decode.sv
